// File: src/minerPkg.sv
package minerPkg;

	typedef logic [31:0] word32;
	typedef logic [255:0] digest256;
	typedef logic [511:0] block512;
	typedef logic [639:0] header640;
	typedef logic [31:0] nonce32;
	typedef logic [6:0] roundCount;

	// which of the three message blocks is being compressed.
	typedef enum logic [1:0] {
		passFirst,
		passSecond,
		passFinal
	} passState;

	// chaining words, a in the top bits so the struct reads as a digest.
	typedef struct packed {
		word32 a;
		word32 b;
		word32 c;
		word32 d;
		word32 e;
		word32 f;
		word32 g;
		word32 h;
	} hashState;

	localparam hashState initHash = '{
		a: 32'h6a09e667,
		b: 32'hbb67ae85,
		c: 32'h3c6ef372,
		d: 32'ha54ff53a,
		e: 32'h510e527f,
		f: 32'h9b05688c,
		g: 32'h1f83d9ab,
		h: 32'h5be0cd19
	};

	// sixteen leading zero bits, compared against the byte-reversed digest.
	localparam digest256 difficultyTarget = {16'h0000, {240{1'b1}}};

	// one load cycle, 64 rounds and one add cycle.
	localparam roundCount passCycles = 7'd66;

endpackage

// File: src/blockAssembler.sv
`timescale 1ns/10ps

module blockAssembler import minerPkg::*; (
	input logic clock,
	input logic rstN,
	input header640 header,
	input nonce32 nonce,
	input logic attemptStart,
	input passState pass,
	input digest256 firstDigest,
	output block512 block
);

	header640 headerReg;
	nonce32 nonceReg;
	block512 blockOne;
	block512 blockTwo;
	block512 blockFinal;

	// inputs are sampled once per attempt, so later changes wait for the next one.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			headerReg <= '0;
			nonceReg <= '0;
		end else if (attemptStart) begin
			headerReg <= header;
			nonceReg <= nonce;
		end
	end

	assign blockOne = headerReg[639:128];

	// the header's own nonce field is dropped and the latched nonce takes its place.
	assign blockTwo = {headerReg[127:32], nonceReg, 1'b1, 319'b0, 64'd640};

	assign blockFinal = {firstDigest, 1'b1, 191'b0, 64'd256}; // second hash covers 256 bits.

	always_comb begin
		case (pass)
			passFirst: block = blockOne;
			passSecond: block = blockTwo;
			default: block = blockFinal;
		endcase
	end

endmodule

// File: src/sha256Core.sv
`timescale 1ns/10ps

module sha256Core import minerPkg::*; (
	input logic clock,
	input logic rstN,
	input roundCount round,
	input block512 block,
	input hashState chainIn,
	output hashState chainOut
);

	localparam word32 roundK [64] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	function automatic word32 bigSigma0(input word32 x);
		return {x[1:0], x[31:2]} ^ {x[12:0], x[31:13]} ^ {x[21:0], x[31:22]};
	endfunction

	function automatic word32 bigSigma1(input word32 x);
		return {x[5:0], x[31:6]} ^ {x[10:0], x[31:11]} ^ {x[24:0], x[31:25]};
	endfunction

	function automatic word32 smallSigma0(input word32 x);
		return {x[6:0], x[31:7]} ^ {x[17:0], x[31:18]} ^ (x >> 3);
	endfunction

	function automatic word32 smallSigma1(input word32 x);
		return {x[16:0], x[31:17]} ^ {x[18:0], x[31:19]} ^ (x >> 10);
	endfunction

	hashState work;
	hashState nextWork;
	word32 [15:0] blkWords;
	word32 [15:0] sched; // sched[15] is the oldest schedule word.
	word32 expanded;
	word32 wt;
	word32 t1;
	word32 t2;
	logic [3:0] wordIdx;
	logic [5:0] kIdx;
	logic compress;

	assign compress = (round != '0) && (round < passCycles - 7'd1);
	assign wordIdx = 4'(round - 7'd1);
	assign kIdx = 6'(round - 7'd1);

	assign blkWords = block; // blkWords[15] is the first message word.

	assign expanded = smallSigma1(sched[1]) + sched[6] + smallSigma0(sched[14]) + sched[15];

	// the first sixteen rounds read the block directly.
	assign wt = (round <= 7'd16) ? blkWords[~wordIdx] : expanded;

	always_comb begin
		t1 = work.h + bigSigma1(work.e) + ((work.e & work.f) ^ (~work.e & work.g))
			+ roundK[kIdx] + wt;
		t2 = bigSigma0(work.a) + ((work.a & work.b) ^ (work.a & work.c) ^ (work.b & work.c));
		nextWork.a = t1 + t2;
		nextWork.b = work.a;
		nextWork.c = work.b;
		nextWork.d = work.c;
		nextWork.e = work.d + t1;
		nextWork.f = work.e;
		nextWork.g = work.f;
		nextWork.h = work.g;
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			work <= '0;
		end else if (round == '0) begin
			work <= chainIn;
		end else if (compress) begin
			work <= nextWork;
		end
	end

	always_ff @(posedge clock) begin
		if (compress) begin
			sched <= {sched[14:0], wt};
		end
	end

	// only meaningful in the last cycle of a pass.
	always_comb begin
		chainOut.a = chainIn.a + work.a;
		chainOut.b = chainIn.b + work.b;
		chainOut.c = chainIn.c + work.c;
		chainOut.d = chainIn.d + work.d;
		chainOut.e = chainIn.e + work.e;
		chainOut.f = chainIn.f + work.f;
		chainOut.g = chainIn.g + work.g;
		chainOut.h = chainIn.h + work.h;
	end

endmodule

// File: src/minerControl.sv
`timescale 1ns/10ps

module minerControl import minerPkg::*; (
	input logic clock,
	input logic rstN,
	input hashState chainOut,
	output passState pass,
	output roundCount round,
	output hashState chainIn,
	output digest256 firstDigest,
	output logic attemptStart,
	output logic finalValid
);

	hashState midState;
	logic lastRound;

	assign lastRound = (round == passCycles - 7'd1);

	// the pass advances on each wrap of the round counter.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			round <= '0;
			pass <= passFirst;
		end else if (lastRound) begin
			round <= '0;
			case (pass)
				passFirst: pass <= passSecond;
				passSecond: pass <= passFinal;
				default: pass <= passFirst;
			endcase
		end else begin
			round <= round + 7'd1;
		end
	end

	// chaining value after block one, then the first digest after block two.
	always_ff @(posedge clock) begin
		if (lastRound && pass == passFirst) begin
			midState <= chainOut;
		end
		if (lastRound && pass == passSecond) begin
			firstDigest <= chainOut;
		end
	end

	// the second hash starts over from the initial words.
	assign chainIn = (pass == passSecond) ? midState : initHash;

	assign attemptStart = (pass == passFirst) && (round == '0);
	assign finalValid = (pass == passFinal) && lastRound;

endmodule

// File: src/targetCheck.sv
`timescale 1ns/10ps

module targetCheck import minerPkg::*; (
	input logic clock,
	input logic rstN,
	input logic finalValid,
	input digest256 digest,
	output digest256 satisfactoryHash,
	output logic hashSuccess,
	output logic ledControl,
	output logic attemptDone
);

	digest256 reversedDigest;
	logic belowTarget;

	// the chain reports hashes as little-endian numbers, so the byte order flips.
	assign reversedDigest = {<<8{digest}};
	assign belowTarget = reversedDigest < difficultyTarget;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			satisfactoryHash <= '0;
			hashSuccess <= 1'b0;
			ledControl <= 1'b0;
			attemptDone <= 1'b0;
		end else begin
			hashSuccess <= finalValid && belowTarget;
			attemptDone <= finalValid;
			if (finalValid) begin
				satisfactoryHash <= digest;
			end
			if (finalValid && belowTarget) begin
				ledControl <= 1'b1; // stays lit until reset.
			end
		end
	end

endmodule

// File: src/minerTop.sv
`timescale 1ns/10ps

module minerTop import minerPkg::*; (
	input logic clock,
	input logic rstN,
	input header640 blockHeader,
	input nonce32 nonce,
	output digest256 satisfactoryHash,
	output logic hashSuccess,
	output logic ledControl,
	output logic attemptDone
);

	passState pass;
	roundCount round;
	hashState chainIn;
	hashState chainOut;
	digest256 firstDigest;
	block512 block;
	logic attemptStart;
	logic finalValid;

	blockAssembler assembler0 (
		.clock(clock),
		.rstN(rstN),
		.header(blockHeader),
		.nonce(nonce),
		.attemptStart(attemptStart),
		.pass(pass),
		.firstDigest(firstDigest),
		.block(block)
	);

	sha256Core core0 (
		.clock(clock),
		.rstN(rstN),
		.round(round),
		.block(block),
		.chainIn(chainIn),
		.chainOut(chainOut)
	);

	minerControl control0 (
		.clock(clock),
		.rstN(rstN),
		.chainOut(chainOut),
		.pass(pass),
		.round(round),
		.chainIn(chainIn),
		.firstDigest(firstDigest),
		.attemptStart(attemptStart),
		.finalValid(finalValid)
	);

	targetCheck check0 (
		.clock(clock),
		.rstN(rstN),
		.finalValid(finalValid),
		.digest(chainOut),
		.satisfactoryHash(satisfactoryHash),
		.hashSuccess(hashSuccess),
		.ledControl(ledControl),
		.attemptDone(attemptDone)
	);

endmodule

// File: tb/miner_asserts.sv
`timescale 1ns/10ps

module minerAsserts import minerPkg::*; (
	input logic clock,
	input logic rstN,
	input logic attemptDone,
	input logic hashSuccess,
	input logic ledControl,
	input digest256 satisfactoryHash
);

	assert property (@(posedge clock) disable iff (!rstN)
		$rose(attemptDone) |-> ##198 attemptDone)
		else $error("attemptDone did not recur 198 cycles later");

	assert property (@(posedge clock) disable iff (!rstN) attemptDone |=> !attemptDone)
		else $error("attemptDone stayed high longer than one cycle");

	assert property (@(posedge clock) hashSuccess |-> attemptDone)
		else $error("hashSuccess rose without attemptDone");

	assert property (@(posedge clock) disable iff (!rstN) ledControl |=> ledControl)
		else $error("ledControl fell while out of reset");

	assert property (@(posedge clock) $rose(rstN) |->
		!attemptDone && !hashSuccess && !ledControl && satisfactoryHash == '0)
		else $error("outputs not cleared in the cycle after reset");

endmodule

bind minerTop minerAsserts asserts0 (.*);

// File: tb/minerChecker.sv
`timescale 1ns/10ps

module minerChecker import minerPkg::*; (
	input logic attemptDone,
	input logic hashSuccess,
	input logic ledControl,
	input digest256 satisfactoryHash
);

	int passCount = 0;
	int failCount = 0;
	logic pendingBad = 1'b0; // set by a failure seen earlier in the same test.

	// called on the falling edge while the DUT is held in reset
	task automatic checkCleared(input string name);
		if (hashSuccess || attemptDone || ledControl || satisfactoryHash != '0) begin
			$display("%s: outputs were not cleared while reset was held", name);
			pendingBad = 1'b1;
		end
	endtask

	task automatic reportTimeout(input string name);
		$display("%s: timed out waiting for attemptDone", name);
		failCount++;
		pendingBad = 1'b0;
	endtask

	task automatic compareRow(input string name, input digest256 expDigest,
		input logic exact, input logic expSuccess, input logic expLed);
		logic bad;
		bad = pendingBad;
		if (exact && satisfactoryHash !== expDigest) begin
			$display("error %s: satisfactoryHash expected %h actual %h", name, expDigest,
				satisfactoryHash);
			bad = 1'b1;
		end
		if (!exact && satisfactoryHash === expDigest) begin
			$display("%s: digest still equals the genesis hash for a different nonce", name);
			bad = 1'b1;
		end
		if (hashSuccess !== expSuccess) begin
			$display("error %s: hashSuccess expected %b actual %b", name, expSuccess,
				hashSuccess);
			bad = 1'b1;
		end
		if (ledControl !== expLed) begin
			$display("error %s: ledControl expected %b actual %b", name, expLed, ledControl);
			bad = 1'b1;
		end
		if (bad) begin
			failCount++;
		end else begin
			$display("ok %s", name);
			passCount++;
		end
		pendingBad = 1'b0;
	endtask

endmodule

// File: tb/minerTb.sv
`timescale 1ns/10ps

module minerTb import minerPkg::*; ();

	// one row of the stimulus table, with the values the checker expects
	typedef struct packed {
		nonce32 nonce;
		digest256 digest; // exact match when exact is set, otherwise must differ.
		logic exact;
		logic success;
		logic led;
		logic midReset;
		logic midChange;
	} rowSpec;

	logic clock;
	logic rstN;
	header640 blockHeader;
	nonce32 nonce;
	digest256 satisfactoryHash;
	logic hashSuccess;
	logic ledControl;
	logic attemptDone;

	header640 genesisHeader;
	digest256 genesisHash;
	nonce32 genesisNonce;
	rowSpec rows [7];
	string rowNames [7];
	logic gotDone;
	logic rowOk;

	minerTop dut0 (
		.clock(clock),
		.rstN(rstN),
		.blockHeader(blockHeader),
		.nonce(nonce),
		.satisfactoryHash(satisfactoryHash),
		.hashSuccess(hashSuccess),
		.ledControl(ledControl),
		.attemptDone(attemptDone)
	);

	minerChecker checker0 (
		.attemptDone(attemptDone),
		.hashSuccess(hashSuccess),
		.ledControl(ledControl),
		.satisfactoryHash(satisfactoryHash)
	);

	always #20 clock = ~clock;

	// raw SHA-256 output bytes; reversed, this is the familiar 000000000019d6... hash.
	task automatic fillTable();
		genesisNonce = 32'h1dac2b7c;
		genesisHeader = {32'h01000000, 256'h0,
			256'h3ba3edfd7a7b12b27ac72c3e67768f617fc81bc3888a51323a9fb8aa4b1e5e4a,
			32'h29ab5f49, 32'hffff001d, genesisNonce};
		genesisHash = 256'h6fe28c0ab6f1b372c1a6a246ae63f74f931e8365e15a089c68d6190000000000;
		rowNames[0] = "nonceBelowGenesis";
		rows[0] = '{32'h1dac2b7b, genesisHash, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
		rowNames[1] = "genesisNonce";
		rows[1] = '{genesisNonce, genesisHash, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0};
		rowNames[2] = "nonceAboveGenesis";
		rows[2] = '{32'h1dac2b7d, genesisHash, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
		rowNames[3] = "zeroNonce";
		rows[3] = '{32'h0, genesisHash, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
		rowNames[4] = "resetMidAttempt";
		rows[4] = '{genesisNonce, genesisHash, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0};
		rowNames[5] = "changeMidAttempt";
		rows[5] = '{genesisNonce, genesisHash, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};
		rowNames[6] = "afterChange";
		rows[6] = '{32'h0, genesisHash, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
	endtask

	// sampled on the falling edge, half a cycle away from any update.
	task automatic waitForDone(input int limit, output logic seen);
		int count;
		count = 0;
		seen = 1'b0;
		while (!seen && count < limit) begin
			@(negedge clock);
			seen = attemptDone;
			count++;
		end
	endtask

	initial begin
		clock = 1'b0;
		rstN = 1'b0;
		nonce = '0;
		fillTable();
		blockHeader = genesisHeader;
		repeat (10) @(posedge clock);
		rstN <= 1'b1;

		for (int i = 0; i < 7; i++) begin
			rowOk = 1'b1;
			@(posedge clock);
			blockHeader <= genesisHeader;
			nonce <= rows[i].nonce;
			waitForDone(500, gotDone); // this attempt may still hold older inputs.
			if (!gotDone) begin
				checker0.reportTimeout(rowNames[i]);
				rowOk = 1'b0;
			end
			if (rowOk && rows[i].midReset) begin
				repeat (60) @(posedge clock);
				rstN <= 1'b0;
				repeat (3) @(posedge clock);
				@(negedge clock);
				checker0.checkCleared(rowNames[i]);
				@(posedge clock);
				rstN <= 1'b1;
				waitForDone(200, gotDone); // first result follows reset in one attempt.
			end else if (rowOk) begin
				if (rows[i].midChange) begin
					repeat (40) @(posedge clock); // still in pass one, before block two is read.
					nonce <= 32'h0;
					blockHeader <= ~genesisHeader;
				end
				waitForDone(500, gotDone);
			end
			if (rowOk && !gotDone) begin
				checker0.reportTimeout(rowNames[i]);
			end else if (rowOk) begin
				checker0.compareRow(rowNames[i], rows[i].digest, rows[i].exact,
					rows[i].success, rows[i].led);
			end
		end

		$display("tests run %0d, passed %0d, failed %0d", 7, checker0.passCount,
			checker0.failCount);
		if (checker0.failCount == 0 && checker0.passCount == 7) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: all.f
src/minerPkg.sv
src/blockAssembler.sv
src/sha256Core.sv
src/minerControl.sv
src/targetCheck.sv
src/minerTop.sv
tb/miner_asserts.sv
tb/minerChecker.sv
tb/minerTb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the log
verilator --binary --timing --assert -f all.f --top-module minerTb -o minerSim > build.log 2>&1 \
	&& ./obj_dir/minerSim > sim.log 2>&1 \
	; cat sim.log \
	; grep -q "^TESTBENCH PASSED$" sim.log \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: build or simulation did not pass, see build.log and sim.log"; exit 1; }
